// ==== sim.f ====
verilog/panel_geom_pkg.sv
verilog/cmd_pkg.sv
verilog/panel_ifs.sv
verilog/frame_buffer.sv
verilog/fill_area.sv
verilog/cmd_control.sv
verilog/wb_cmd_slave.sv
verilog/panel_top.sv
test/tb_panel_top.sv

// ==== Makefile ====
# Verilator build and run of the framebuffer command engine testbench.

VERILATOR ?= verilator
TOP       ?= tb_panel_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^All checks passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_panel_top.sv ====
// Directed testbench for the framebuffer command engine. Drives the Wishbone
// port and compares status and framebuffer bytes against a byte-level model.
`default_nettype none

module tb_panel_top;
    timeunit 1ns;
    timeprecision 100ps;
    import cmd_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS = 13;                      // Five directed tests and eight random fills.
    localparam int CYCLES_PER_TEST = 2000;
    localparam int ACK_TIMEOUT = 16;
    localparam int POLL_LIMIT = 2 * 256;

    logic clk;
    logic reset;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [WB_ADDR_BITS-1:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic wb_ack;

    logic [7:0] shadow [256];                           // Expected framebuffer, {row, column, byte}.
    int checks;
    int mismatches;
    int failures;
    integer seed;

    panel_top u_panel_top (
        .clk(clk),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Watchdog expired at %0t before the tests finished", $time);
        $display("Checks failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Bus model and checks
    // ------------------------------------------------------------
    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH at %0t: %s, got 0x%h, expected 0x%h",
                     $time, msg, actual, expected);
        end
    endtask

    task automatic bus_cycle(input logic write, input logic [WB_ADDR_BITS-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = write;
        wb_adr = addr;
        wb_dat_w = wdata;
        rdata = '0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < ACK_TIMEOUT);
        if (wb_ack) begin
            rdata = wb_dat_r;
        end else begin
            failures++;
            $display("Bus cycle to register %0d was never acknowledged", addr);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADDR_BITS-1:0] addr, input logic [31:0] data);
        logic [31:0] ignored;
        bus_cycle(1'b1, addr, data, ignored);
    endtask

    task automatic wb_read(input logic [WB_ADDR_BITS-1:0] addr, output logic [31:0] data);
        bus_cycle(1'b0, addr, 32'd0, data);
    endtask

    task automatic issue(input opcode_t op);
        wb_write(REG_CMD, {30'd0, op});
    endtask

    task automatic fill_rect(input logic [7:0] x, input logic [7:0] y, input logic [7:0] w,
                             input logic [7:0] h, input logic [15:0] color);
        wb_write(REG_RECT, {h, w, y, x});
        wb_write(REG_COLOR, {16'd0, color});
        issue(OP_FILL);
    endtask

    task automatic poll_idle();
        logic [31:0] status;
        int reads;
        status = 32'd1;
        reads = 0;
        while (status[0] && reads < POLL_LIMIT) begin
            wb_read(REG_STATUS, status);
            reads++;
        end
        if (status[0]) begin
            failures++;
            $display("Busy was still set after %0d status reads", reads);
        end
    endtask

    // Clipped fill into the model, colour byte 0 at the even address.
    function automatic void paint_shadow(input logic [7:0] x, input logic [7:0] y,
                                         input logic [7:0] w, input logic [7:0] h,
                                         input logic [15:0] color);
        logic [7:0] addr;
        for (int r = int'(y); r < int'(y) + int'(h) && r < 8; r++) begin
            for (int c = int'(x); c < int'(x) + int'(w) && c < 16; c++) begin
                addr = 8'(r * 32 + c * 2);
                shadow[addr] = color[7:0];
                shadow[addr + 8'd1] = color[15:8];
            end
        end
    endfunction

    function automatic void clear_shadow();
        for (int a = 0; a < 256; a++) begin
            shadow[a] = 8'd0;
        end
    endfunction

    task automatic compare_frame(input string label);
        logic [31:0] data;
        for (int a = 0; a < 256; a++) begin
            wb_write(REG_RD_ADDR, 32'(a));
            wb_read(REG_RD_DATA, data);
            check(data, {24'd0, shadow[a]}, $sformatf("%s, byte %0d", label, a));
        end
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------
    task automatic reset_and_blank();
        logic [31:0] data;
        check({31'd0, wb_ack}, 32'd0, "wb_ack after reset");
        wb_read(REG_STATUS, data);
        check(data, 32'd0, "STATUS after reset");
        issue(OP_BLANK);
        poll_idle();
        clear_shadow();
        compare_frame("BLANK after reset");
    endtask

    task automatic rectangle_fill();
        logic [31:0] data;
        fill_rect(8'd3, 8'd2, 8'd4, 8'd3, 16'hA55A);
        poll_idle();
        paint_shadow(8'd3, 8'd2, 8'd4, 8'd3, 16'hA55A);
        compare_frame("rectangle fill");
        wb_read(REG_STATUS, data);
        check(data, 32'd0, "STATUS after rectangle fill");
    endtask

    task automatic clipped_fill();
        logic [31:0] data;
        fill_rect(8'd14, 8'd6, 8'd5, 8'd5, 16'h3CC3);
        poll_idle();
        paint_shadow(8'd14, 8'd6, 8'd5, 8'd5, 16'h3CC3);
        compare_frame("clipped fill");
        wb_read(REG_STATUS, data);
        check(data, 32'd0, "STATUS after clipped fill");
    endtask

    task automatic rejected_commands();
        logic [31:0] data;
        fill_rect(8'd0, 8'd0, 8'd16, 8'd8, 16'h1EE1);
        wb_read(REG_STATUS, data);
        check({31'd0, data[0]}, 32'd1, "busy during full-panel fill");
        issue(OP_BLANK);                                // Lands while the fill runs.
        poll_idle();
        paint_shadow(8'd0, 8'd0, 8'd16, 8'd8, 16'h1EE1);
        wb_read(REG_STATUS, data);
        check(data, 32'h2, "reject after command while busy");
        wb_write(REG_STATUS, 32'd0);
        wb_read(REG_STATUS, data);
        check(data, 32'd0, "STATUS after reject clear");
        fill_rect(8'd5, 8'd1, 8'd0, 8'd2, 16'hFFFF);
        wb_read(REG_STATUS, data);
        check(data, 32'h2, "reject after zero-width fill");
        wb_write(REG_STATUS, 32'd0);
        wb_read(REG_STATUS, data);
        check(data, 32'd0, "STATUS after second reject clear");
        compare_frame("memory after rejected commands");
    endtask

    task automatic random_fill(input int index);
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] w;
        logic [7:0] h;
        logic [15:0] color;
        logic [31:0] data;
        x = 8'($random(seed) & 15);
        y = 8'($random(seed) & 7);
        w = 8'(1 + ($random(seed) & 15));
        h = 8'(1 + ($random(seed) & 7));
        color = 16'($random(seed));
        fill_rect(x, y, w, h, color);
        poll_idle();
        paint_shadow(x, y, w, h, color);
        compare_frame($sformatf("random fill %0d", index));
        wb_read(REG_STATUS, data);
        check(data, 32'd0, $sformatf("STATUS after random fill %0d", index));
    endtask

    task automatic blank_after_draw();
        issue(OP_BLANK);
        poll_idle();
        clear_shadow();
        compare_frame("BLANK after drawing");
    endtask

    initial begin
        seed = 80;
        checks = 0;
        mismatches = 0;
        failures = 0;
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = 32'd0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        reset_and_blank();
        rectangle_fill();
        clipped_fill();
        rejected_commands();
        for (int i = 0; i < 8; i++) begin
            random_fill(i);
        end
        blank_after_draw();

        $display("Run complete with %0d checks, %0d mismatches, %0d other failures",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/panel_top.sv ====
// Top level of the framebuffer command engine. Connects the Wishbone slave,
// sequencer, area walker and framebuffer behind plain Wishbone ports.
`default_nettype none

module panel_top (
    input  wire logic                             clk,
    input  wire logic                             reset,
    input  wire logic                             wb_cyc,
    input  wire logic                             wb_stb,
    input  wire logic                             wb_we,
    input  wire logic [cmd_pkg::WB_ADDR_BITS-1:0] wb_adr,
    input  wire logic [31:0]                      wb_dat_w,
    output logic      [31:0]                      wb_dat_r,
    output logic                                  wb_ack
);
    import panel_geom_pkg::*;
    import cmd_pkg::*;

    fill_cmd_t cmd;
    logic cmd_valid;
    logic clear_reject;
    logic busy;
    logic rejected;
    logic [FB_ADDR_BITS-1:0] rd_addr;
    logic [7:0] rd_data;

    fill_cmd_if fill_bus ();
    pixel_write_if pixel_bus ();

    wb_cmd_slave u_wb_cmd_slave (
        .clk(clk),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .busy(busy),
        .rejected(rejected),
        .rd_data(rd_data),
        .cmd(cmd),
        .cmd_valid(cmd_valid),
        .clear_reject(clear_reject),
        .rd_addr(rd_addr)
    );

    cmd_control u_cmd_control (
        .clk(clk),
        .reset(reset),
        .cmd(cmd),
        .cmd_valid(cmd_valid),
        .clear_reject(clear_reject),
        .busy(busy),
        .rejected(rejected),
        .fill(fill_bus.control)
    );

    fill_area u_fill_area (
        .clk(clk),
        .reset(reset),
        .fill(fill_bus.engine),
        .wr(pixel_bus.source)
    );

    frame_buffer u_frame_buffer (
        .clk(clk),
        .wr(pixel_bus.ram),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

endmodule

`default_nettype wire

// ==== verilog/wb_cmd_slave.sv ====
// Wishbone classic register slave. Holds the rectangle, colour and readback
// address, launches commands and returns status and framebuffer bytes.
`default_nettype none

module wb_cmd_slave (
    input  wire logic                                      clk,
    input  wire logic                                      reset,
    input  wire logic                                      wb_cyc,
    input  wire logic                                      wb_stb,
    input  wire logic                                      wb_we,
    input  wire logic [cmd_pkg::WB_ADDR_BITS-1:0]          wb_adr,
    input  wire logic [31:0]                               wb_dat_w,
    output logic      [31:0]                               wb_dat_r,
    output logic                                           wb_ack,
    input  wire logic                                      busy,
    input  wire logic                                      rejected,
    input  wire logic [7:0]                                rd_data,
    output cmd_pkg::fill_cmd_t                             cmd,
    output logic                                           cmd_valid,
    output logic                                           clear_reject,
    output logic      [panel_geom_pkg::FB_ADDR_BITS-1:0]   rd_addr
);
    import panel_geom_pkg::*;
    import cmd_pkg::*;

    logic request;
    logic [31:0] rect_reg;
    logic [COLOR_BITS-1:0] color_reg;
    opcode_t op_reg;
    logic [31:0] status;
    logic [31:0] read_data;

    assign request = wb_cyc && wb_stb && !wb_ack;        // New cycle, not yet acked.

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            cmd_valid <= 1'b0;
            clear_reject <= 1'b0;
        end else begin
            wb_ack <= request;
            cmd_valid <= request && wb_we && (wb_adr == REG_CMD);
            clear_reject <= request && wb_we && (wb_adr == REG_STATUS);
        end
    end

    always_ff @(posedge clk) begin
        if (request && wb_we) begin
            case (wb_adr)
                REG_CMD: op_reg <= opcode_t'(wb_dat_w[1:0]);
                REG_RECT: rect_reg <= wb_dat_w;
                REG_COLOR: color_reg <= wb_dat_w[COLOR_BITS-1:0];
                REG_RD_ADDR: rd_addr <= wb_dat_w[FB_ADDR_BITS-1:0];
                default: ;
            endcase
        end
        if (request) begin
            wb_dat_r <= read_data;
        end
    end

    always_comb begin
        status = '0;
        status[STATUS_BUSY] = busy;
        status[STATUS_REJECT] = rejected;
        case (wb_adr)
            REG_CMD: read_data = {30'd0, op_reg};
            REG_RECT: read_data = rect_reg;
            REG_COLOR: read_data = {{(32 - COLOR_BITS){1'b0}}, color_reg};
            REG_STATUS: read_data = status;
            REG_RD_ADDR: read_data = {{(32 - FB_ADDR_BITS){1'b0}}, rd_addr};
            REG_RD_DATA: read_data = {24'd0, rd_data};
            default: read_data = '0;
        endcase
    end

    // Oversized width and height saturate to the panel so they fit the command fields.
    always_comb begin
        cmd.opcode = op_reg;
        cmd.x = rect_reg[7:0];
        cmd.y = rect_reg[15:8];
        cmd.width = (rect_reg[23:16] > 8'(PANEL_WIDTH)) ?
            (COL_BITS + 1)'(PANEL_WIDTH) : rect_reg[16 +: COL_BITS + 1];
        cmd.height = (rect_reg[31:24] > 8'(PANEL_HEIGHT)) ?
            (ROW_BITS + 1)'(PANEL_HEIGHT) : rect_reg[24 +: ROW_BITS + 1];
        cmd.color = color_reg;
    end

endmodule

`default_nettype wire

// ==== verilog/cmd_control.sv ====
// Command sequencer. Checks and clips incoming commands, launches the area
// walker and reports busy and the sticky reject flag.
`default_nettype none

module cmd_control (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire cmd_pkg::fill_cmd_t cmd,
    input  wire logic               cmd_valid,
    input  wire logic               clear_reject,
    output logic                    busy,
    output logic                    rejected,
    fill_cmd_if.control             fill
);
    import panel_geom_pkg::*;
    import cmd_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LAUNCH,
        RUNNING,
        FINISH
    } state_t;

    state_t state;
    logic can_accept;
    logic fill_ok;
    logic [COL_BITS:0] room_w;
    logic [COL_BITS:0] clip_w;
    logic [ROW_BITS:0] room_h;
    logic [ROW_BITS:0] clip_h;

    assign can_accept = (state == IDLE) || (state == FINISH);
    assign busy = (state == LAUNCH) || (state == RUNNING);
    assign fill.start = (state == LAUNCH);

    // ------------------------------------------------------------
    // Validation and clipping
    // ------------------------------------------------------------
    assign fill_ok = (cmd.opcode == OP_FILL) && (cmd.x < 8'(PANEL_WIDTH)) &&
                     (cmd.y < 8'(PANEL_HEIGHT)) && (cmd.width != '0) && (cmd.height != '0);
    assign room_w = (COL_BITS + 1)'(PANEL_WIDTH) - {1'b0, cmd.x[COL_BITS-1:0]};
    assign room_h = (ROW_BITS + 1)'(PANEL_HEIGHT) - {1'b0, cmd.y[ROW_BITS-1:0]};
    assign clip_w = (cmd.width > room_w) ? room_w : cmd.width;
    assign clip_h = (cmd.height > room_h) ? room_h : cmd.height;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            rejected <= 1'b0;
        end else begin
            if (clear_reject) rejected <= 1'b0;
            case (state)
                IDLE, FINISH: begin
                    state <= IDLE;
                    if (cmd_valid) begin
                        if (cmd.opcode == OP_BLANK || fill_ok) state <= LAUNCH;
                        else rejected <= 1'b1;                  // Empty, off-panel or unknown.
                    end
                end
                LAUNCH: state <= RUNNING;
                RUNNING: if (fill.done) state <= FINISH;
                default: state <= IDLE;
            endcase
            if (cmd_valid && !can_accept) rejected <= 1'b1;     // Dropped while busy.
        end
    end

    // Fill fields only change when a command is taken, so they hold while busy.
    always_ff @(posedge clk) begin
        if (can_accept && cmd_valid) begin
            if (cmd.opcode == OP_BLANK) begin
                fill.x <= '0;
                fill.y <= '0;
                fill.width <= (COL_BITS + 1)'(PANEL_WIDTH);
                fill.height <= (ROW_BITS + 1)'(PANEL_HEIGHT);
                fill.color <= '0;
            end else begin
                fill.x <= cmd.x[COL_BITS-1:0];
                fill.y <= cmd.y[ROW_BITS-1:0];
                fill.width <= clip_w;
                fill.height <= clip_h;
                fill.color <= cmd.color;
            end
        end
    end

    // The walker reports done only for the fill that is running.
    a_done_while_running: assert property (@(posedge clk) disable iff (reset)
        fill.done |-> (state == RUNNING));

endmodule

`default_nettype wire

// ==== verilog/fill_area.sv ====
// Rectangle walker. After start it writes one framebuffer byte per clock,
// byte fastest, then column, then row, and pulses done after the last write.
`default_nettype none

module fill_area (
    input  wire logic    clk,
    input  wire logic    reset,
    fill_cmd_if.engine   fill,
    pixel_write_if.source wr
);
    import panel_geom_pkg::*;

    logic active;
    logic [ROW_BITS-1:0] row_off;
    logic [COL_BITS-1:0] col_off;
    logic [BYTE_BITS-1:0] byte_sel;
    logic last_byte;
    logic last_col;
    logic last_row;

    assign last_byte = (byte_sel == BYTE_BITS'(BYTES_PER_PIXEL - 1));
    assign last_col = ({1'b0, col_off} == fill.width - 1'b1);
    assign last_row = ({1'b0, row_off} == fill.height - 1'b1);

    // ------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------
    assign wr.write_enable = active;
    assign wr.row = fill.y + row_off;
    assign wr.column = fill.x + col_off;
    assign wr.pixel = byte_sel;
    assign wr.data = fill.color[byte_sel * 8 +: 8];     // Little-endian by byte index.

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            fill.done <= 1'b0;
            row_off <= '0;
            col_off <= '0;
            byte_sel <= '0;
        end else begin
            fill.done <= 1'b0;
            if (fill.start) begin
                active <= 1'b1;
                row_off <= '0;
                col_off <= '0;
                byte_sel <= '0;
            end else if (active) begin
                if (!last_byte) begin
                    byte_sel <= byte_sel + 1'b1;
                end else begin
                    byte_sel <= '0;
                    if (!last_col) begin
                        col_off <= col_off + 1'b1;
                    end else begin
                        col_off <= '0;
                        if (!last_row) begin
                            row_off <= row_off + 1'b1;
                        end else begin
                            active <= 1'b0;             // Last byte of the area.
                            fill.done <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // The sequencer's clipping must keep every write inside the panel.
    a_write_on_panel: assert property (@(posedge clk) disable iff (reset)
        wr.write_enable |-> (int'(fill.x) + int'(col_off) < PANEL_WIDTH) &&
                            (int'(fill.y) + int'(row_off) < PANEL_HEIGHT));

endmodule

`default_nettype wire

// ==== verilog/frame_buffer.sv ====
// Byte-wide framebuffer RAM, one write port from the area walker and one
// registered read port for bus readback.
`default_nettype none

module frame_buffer (
    input  wire logic                                    clk,
    pixel_write_if.ram                                   wr,
    input  wire logic [panel_geom_pkg::FB_ADDR_BITS-1:0] rd_addr,
    output logic      [7:0]                              rd_data
);
    import panel_geom_pkg::*;

    logic [7:0] mem [FB_DEPTH];
    logic [FB_ADDR_BITS-1:0] wr_addr;

    assign wr_addr = {wr.row, wr.column, wr.pixel};     // Row-major, byte fastest.

    always_ff @(posedge clk) begin
        if (wr.write_enable) begin
            mem[wr_addr] <= wr.data;
        end
        rd_data <= mem[rd_addr];                        // One cycle read latency.
    end

endmodule

`default_nettype wire

// ==== verilog/panel_ifs.sv ====
// Internal buses of the fill engine: fill launch from the sequencer and
// byte writes from the area walker into the framebuffer.
`default_nettype none

interface fill_cmd_if;
    import panel_geom_pkg::*;

    logic start;
    logic [COL_BITS-1:0] x;
    logic [ROW_BITS-1:0] y;
    logic [COL_BITS:0] width;
    logic [ROW_BITS:0] height;
    logic [COLOR_BITS-1:0] color;
    logic done;

    modport control (output start, x, y, width, height, color, input done);
    modport engine (input start, x, y, width, height, color, output done);
endinterface

interface pixel_write_if;
    import panel_geom_pkg::*;

    logic [ROW_BITS-1:0] row;
    logic [COL_BITS-1:0] column;
    logic [BYTE_BITS-1:0] pixel;
    logic [7:0] data;
    logic write_enable;

    modport source (output row, column, pixel, data, write_enable);
    modport ram (input row, column, pixel, data, write_enable);
endinterface

`default_nettype wire

// ==== verilog/cmd_pkg.sv ====
// Command opcodes, command struct and Wishbone register map of the fill engine.
`default_nettype none

package cmd_pkg;

    localparam int WB_ADDR_BITS = 3;
    localparam int RECT_FIELD_BITS = 8;                 // One byte per field in REG_RECT.

    typedef enum logic [1:0] {
        OP_NONE,
        OP_FILL,
        OP_BLANK
    } opcode_t;

    // x and y keep the full register byte so off-panel origins can be caught.
    typedef struct packed {
        opcode_t opcode;
        logic [RECT_FIELD_BITS-1:0] x;
        logic [RECT_FIELD_BITS-1:0] y;
        logic [panel_geom_pkg::COL_BITS:0] width;
        logic [panel_geom_pkg::ROW_BITS:0] height;
        logic [panel_geom_pkg::COLOR_BITS-1:0] color;
    } fill_cmd_t;

    // ------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------
    localparam logic [WB_ADDR_BITS-1:0] REG_CMD = 3'd0;
    localparam logic [WB_ADDR_BITS-1:0] REG_RECT = 3'd1;       // x, y, width, height bytes.
    localparam logic [WB_ADDR_BITS-1:0] REG_COLOR = 3'd2;
    localparam logic [WB_ADDR_BITS-1:0] REG_STATUS = 3'd3;
    localparam logic [WB_ADDR_BITS-1:0] REG_RD_ADDR = 3'd4;
    localparam logic [WB_ADDR_BITS-1:0] REG_RD_DATA = 3'd5;

    localparam int STATUS_BUSY = 0;
    localparam int STATUS_REJECT = 1;                   // Sticky, cleared by a STATUS write.

endpackage

`default_nettype wire

// ==== verilog/panel_geom_pkg.sv ====
// Panel geometry and framebuffer address widths for the LED matrix datapath.
// Imported by every block that forms or decodes a pixel byte address.
`default_nettype none

package panel_geom_pkg;

    // ------------------------------------------------------------
    // Panel size
    // ------------------------------------------------------------
    localparam int PANEL_WIDTH = 16;                    // Columns.
    localparam int PANEL_HEIGHT = 8;                    // Rows.
    localparam int BYTES_PER_PIXEL = 2;                 // Colour bytes per pixel.

    // ------------------------------------------------------------
    // Address fields
    // ------------------------------------------------------------
    localparam int COL_BITS = $clog2(PANEL_WIDTH);
    localparam int ROW_BITS = $clog2(PANEL_HEIGHT);
    localparam int BYTE_BITS = $clog2(BYTES_PER_PIXEL);

    // Byte address is {row, column, byte}.
    localparam int FB_ADDR_BITS = ROW_BITS + COL_BITS + BYTE_BITS;
    localparam int FB_DEPTH = 1 << FB_ADDR_BITS;        // 256 bytes.

    localparam int COLOR_BITS = BYTES_PER_PIXEL * 8;

endpackage

`default_nettype wire
